/* all.f */
source/imuldiv_pkg.sv
source/imuldiv_decode.sv
source/imuldiv_mul_iter.sv
source/imuldiv_div_iter.sv
source/imuldiv_result.sv
source/imuldiv_unit.sv
sim/imuldiv_checker.sv
sim/imuldiv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the imuldiv testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module imuldiv_tb -f all.f -o imuldiv_sim
./obj_dir/imuldiv_sim | tee sim.log

if grep -q "^test passed$" sim.log; then
  echo "simulation result: PASS"
else
  echo "simulation result: FAIL"
  exit 1
fi

/* sim/imuldiv_checker.sv */
//----------------------------------------------------------------------
// scoreboard for imuldiv_unit, one expectation per request transfer
// table values are checked too where tbl_known comes with the request
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module imuldiv_checker (
  input  wire                      clk,
  input  wire                      reset,
  input  wire imuldiv_pkg::muldiv_fn_e req_fn,
  input  wire imuldiv_pkg::word_t  req_a,
  input  wire imuldiv_pkg::word_t  req_b,
  input  wire                      req_val,
  input  wire                      req_rdy,
  input  wire imuldiv_pkg::dword_t resp_result,
  input  wire                      resp_val,
  input  wire                      resp_rdy,
  input  wire imuldiv_pkg::dword_t tbl_exp,
  input  wire                      tbl_known,
  output int                       n_pass,
  output int                       n_fail,
  output int                       n_errors
);

  import imuldiv_pkg::*;

  // edges from request transfer to the capture edge
  localparam int resp_latency = 34;

  typedef struct packed {
    muldiv_fn_e  fn;
    word_t       a;
    word_t       b;
    dword_t      model;
    dword_t      table_exp;
    logic        known;
    logic [31:0] cycle;
  } expect_t;

  expect_t pending[$];
  expect_t head;
  int      cycle;
  int      n_tests;
  logic    was_reset;
  logic    prev_val;
  logic    prev_rdy;
  dword_t  prev_result;

  // reference arithmetic, signed ops in 64 bits
  // min value over -1 wraps back to min value once cut to 32 bits
  function automatic dword_t model_result(input muldiv_fn_e fn, input word_t a,
                                          input word_t b);
    longint sa;
    longint sb;
    dword_t r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (fn)
      fn_mul:  r = dword_t'(sa * sb);
      fn_div:  r = (b == '0) ? {32'h0, 32'hffff_ffff} : {32'h0, word_t'(sa / sb)};
      fn_rem:  r = (b == '0) ? {32'h0, a} : {32'h0, word_t'(sa % sb)};
      fn_divu: r = (b == '0) ? {32'h0, 32'hffff_ffff} : {32'h0, a / b};
      default: r = (b == '0) ? {32'h0, a} : {32'h0, a % b};
    endcase
    return r;
  endfunction

  //----------------------------------------------------------------------
  // response compare, one line per test
  //----------------------------------------------------------------------

  task automatic check_response(input expect_t e);
    muldiv_fn_e f;
    logic       ok;
    f  = e.fn;
    ok = (resp_result === e.model);
    if (!ok) begin
      $display("[ERROR] %0t: %s a=%h b=%h result %h, model %h", $time, f.name(),
               e.a, e.b, resp_result, e.model);
    end
    if (e.known && (resp_result !== e.table_exp)) begin
      ok = 1'b0;
      $display("[ERROR] %0t: %s a=%h b=%h result %h, table %h", $time, f.name(),
               e.a, e.b, resp_result, e.table_exp);
    end
    n_tests++;
    if (ok) n_pass++;
    else n_fail++;
    $display("test %0d %s a=%h b=%h result=%h %s", n_tests, f.name(), e.a, e.b,
             resp_result, ok ? "ok" : "mismatch");
  endtask

  //----------------------------------------------------------------------
  // port monitor, samples values from before each edge
  //----------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      cycle     = 0;
      n_tests   = 0;
      n_pass    = 0;
      n_fail    = 0;
      n_errors  = 0;
      was_reset = 1'b1;
      prev_val  = 1'b0;
      prev_rdy  = 1'b0;
      pending.delete();
    end else begin
      cycle = cycle + 1;
      // idle state right after reset
      if (was_reset && ((resp_val !== 1'b0) || (req_rdy !== 1'b1))) begin
        $display("[ERROR] %0t: unit not idle after reset, resp_val=%b req_rdy=%b",
                 $time, resp_val, req_rdy);
        n_errors++;
      end
      was_reset = 1'b0;
      // no request is taken while one is in flight or its response waits
      if (req_rdy && (resp_val || (pending.size() > 0))) begin
        $display("[ERROR] %0t: req_rdy high while a request is in flight", $time);
        n_errors++;
      end
      if (prev_val && !prev_rdy && resp_val && (resp_result !== prev_result)) begin
        $display("[ERROR] %0t: held response changed from %h to %h", $time,
                 prev_result, resp_result);
        n_errors++;
      end
      // resp_val is first seen one edge after the capture edge
      if (resp_val && !prev_val && (pending.size() > 0)) begin
        head = pending[0];
        if (cycle - int'(head.cycle) - 1 != resp_latency) begin
          $display("[ERROR] %0t: resp_val rose %0d edges after the request, expected %0d",
                   $time, cycle - int'(head.cycle) - 1, resp_latency);
          n_errors++;
        end
      end
      if (req_val && req_rdy) begin
        head.fn        = req_fn;
        head.a         = req_a;
        head.b         = req_b;
        head.model     = model_result(req_fn, req_a, req_b);
        head.table_exp = tbl_exp;
        head.known     = tbl_known;
        head.cycle     = 32'(cycle);
        pending.push_back(head);
      end
      if (resp_val && resp_rdy) begin
        if (pending.size() == 0) begin
          $display("a response was delivered while no request was outstanding");
          n_errors++;
        end else begin
          head = pending.pop_front();
          check_response(head);
        end
      end
      prev_val    = resp_val;
      prev_rdy    = resp_rdy;
      prev_result = resp_result;
    end
  end

endmodule

`default_nettype wire

/* sim/imuldiv_tb.sv */
//----------------------------------------------------------------------
// testbench for imuldiv_unit, directed table then seeded random entries
// random entries carry no table value, the checker model covers them
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module imuldiv_tb;

  import imuldiv_pkg::*;

  localparam int n_tests      = 30;
  localparam int max_delay    = 7;
  localparam int reset_cycles = 8;
  // per test: latency, both handshakes and the longest stall
  localparam int limit_cycles = reset_cycles + n_tests * (40 + max_delay);

  typedef struct packed {
    muldiv_fn_e fn;
    word_t      a;
    word_t      b;
    dword_t     expected;
    logic       known;
    logic [3:0] delay;
  } test_vec_t;

  logic       clk;
  logic       reset;
  muldiv_fn_e req_fn;
  word_t      req_a;
  word_t      req_b;
  logic       req_val;
  logic       req_rdy;
  dword_t     resp_result;
  logic       resp_val;
  logic       resp_rdy;
  dword_t     tbl_exp;
  logic       tbl_known;
  int         n_pass;
  int         n_fail;
  int         n_errors;
  test_vec_t  tests [n_tests];
  int         n_loaded;
  integer     seed;

  imuldiv_unit dut0 (
    .clk(clk), .reset(reset), .req_fn(req_fn), .req_a(req_a), .req_b(req_b),
    .req_val(req_val), .req_rdy(req_rdy), .resp_result(resp_result),
    .resp_val(resp_val), .resp_rdy(resp_rdy)
  );

  imuldiv_checker chk0 (
    .clk(clk), .reset(reset), .req_fn(req_fn), .req_a(req_a), .req_b(req_b),
    .req_val(req_val), .req_rdy(req_rdy), .resp_result(resp_result),
    .resp_val(resp_val), .resp_rdy(resp_rdy), .tbl_exp(tbl_exp),
    .tbl_known(tbl_known), .n_pass(n_pass), .n_fail(n_fail), .n_errors(n_errors)
  );

  always #5 clk = ~clk;

  task automatic add_vec(input muldiv_fn_e fn, input word_t a, input word_t b,
                         input dword_t expected, input int delay);
    tests[n_loaded] = {fn, a, b, expected, 1'b1, 4'(delay)};
    n_loaded++;
  endtask

  task automatic add_random();
    test_vec_t   v;
    int unsigned sh;
    v.fn       = muldiv_fn_e'(3'($unsigned($random(seed)) % 5));
    v.a        = $random(seed);
    // shortened divisors spread the quotient sizes
    sh         = $unsigned($random(seed)) % 32;
    v.b        = word_t'($random(seed)) >> sh;
    v.expected = '0;
    v.known    = 1'b0;
    v.delay    = 4'($unsigned($random(seed)) % (max_delay + 1));
    tests[n_loaded] = v;
    n_loaded++;
  endtask

  // present one request, then stall the response for the entry's delay
  // the following request already waits on the port during the run
  task automatic run_one(input test_vec_t v, input test_vec_t following,
                         input logic more);
    int held;
    req_fn    <= v.fn;
    req_a     <= v.a;
    req_b     <= v.b;
    req_val   <= 1'b1;
    tbl_exp   <= v.expected;
    tbl_known <= v.known;
    resp_rdy  <= (v.delay == 4'd0);
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    if (more) begin
      req_fn    <= following.fn;
      req_a     <= following.a;
      req_b     <= following.b;
      tbl_exp   <= following.expected;
      tbl_known <= following.known;
    end else begin
      req_val <= 1'b0;
    end
    held = 0;
    @(posedge clk);
    while (!(resp_val && resp_rdy)) begin
      if (resp_val) begin
        held++;
        if (held >= int'(v.delay)) resp_rdy <= 1'b1;
      end
      @(posedge clk);
    end
    resp_rdy <= 1'b0;
  endtask

  //----------------------------------------------------------------------
  // main sequence
  //----------------------------------------------------------------------

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    req_fn    = fn_mul;
    req_a     = '0;
    req_b     = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    tbl_exp   = '0;
    tbl_known = 1'b0;
    seed      = 32'hb274;
    n_loaded  = 0;
    // mul, every sign pairing plus zero and the min value
    add_vec(fn_mul,  32'd3,         32'd5,         64'h0000_0000_0000_000f, 0);
    add_vec(fn_mul,  32'hffff_fffd, 32'd5,         64'hffff_ffff_ffff_fff1, 3);
    add_vec(fn_mul,  32'd7,         32'hffff_fffa, 64'hffff_ffff_ffff_ffd6, 0);
    add_vec(fn_mul,  32'hffff_fffc, 32'hffff_fff8, 64'h0000_0000_0000_0020, 1);
    add_vec(fn_mul,  32'd0,         32'h1234_5678, 64'h0000_0000_0000_0000, 0);
    add_vec(fn_mul,  32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000, 7);
    add_vec(fn_mul,  32'h7fff_ffff, 32'h7fff_ffff, 64'h3fff_ffff_0000_0001, 2);
    add_vec(fn_mul,  32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000, 0);
    // signed divide truncates toward zero, remainder follows the dividend
    add_vec(fn_div,  32'hffff_ff9c, 32'd7,         64'h0000_0000_ffff_fff2, 5);
    add_vec(fn_div,  32'd100,       32'hffff_fff9, 64'h0000_0000_ffff_fff2, 0);
    add_vec(fn_div,  32'hffff_ff9c, 32'hffff_fff9, 64'h0000_0000_0000_000e, 0);
    add_vec(fn_rem,  32'hffff_ff9c, 32'd7,         64'h0000_0000_ffff_fffe, 4);
    add_vec(fn_rem,  32'd100,       32'hffff_fff9, 64'h0000_0000_0000_0002, 1);
    add_vec(fn_divu, 32'hffff_ffff, 32'd2,         64'h0000_0000_7fff_ffff, 0);
    add_vec(fn_remu, 32'hffff_ffff, 32'd10,        64'h0000_0000_0000_0005, 6);
    // zero divisor and min value over -1
    add_vec(fn_div,  32'd1234,      32'd0,         64'h0000_0000_ffff_ffff, 0);
    add_vec(fn_rem,  32'hffff_fffb, 32'd0,         64'h0000_0000_ffff_fffb, 2);
    add_vec(fn_divu, 32'd7,         32'd0,         64'h0000_0000_ffff_ffff, 0);
    add_vec(fn_remu, 32'h1234_5678, 32'd0,         64'h0000_0000_1234_5678, 3);
    add_vec(fn_div,  32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000, 0);
    add_vec(fn_rem,  32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_0000_0000, 7);
    add_vec(fn_remu, 32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000, 1);
    while (n_loaded < n_tests) add_random();

    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      run_one(tests[i], tests[(i + 1) % n_tests], (i + 1) < n_tests);
    end
    repeat (2) @(posedge clk);

    $display("tests %0d, passed %0d, failed %0d, other errors %0d",
             n_tests, n_pass, n_fail, n_errors);
    if ((n_pass == n_tests) && (n_fail == 0) && (n_errors == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout, the tests did not finish within %0d cycles", limit_cycles);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/imuldiv_decode.sv */
//----------------------------------------------------------------------
// request decode, one request at a time
// req_take must only be high while the whole unit is idle
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module imuldiv_decode (
  input  wire                      clk,
  input  wire                      reset,
  input  wire imuldiv_pkg::muldiv_fn_e req_fn,
  input  wire imuldiv_pkg::word_t  req_a,
  input  wire imuldiv_pkg::word_t  req_b,
  input  wire                      req_val,
  input  wire                      req_take,
  output imuldiv_pkg::muldiv_op_t  dec_op,
  output logic                     dec_go,
  output logic                     busy
);

  import imuldiv_pkg::*;

  logic       accept;
  logic       is_signed;
  logic       is_div;
  word_t      a_mag;
  word_t      b_mag;
  muldiv_op_t op_next;

  // request transfer edge
  assign accept = req_val && req_take;

  always_comb begin
    // mul, div and rem work on two's-complement operands
    is_signed = (req_fn == fn_mul) || (req_fn == fn_div) || (req_fn == fn_rem);
    is_div    = (req_fn != fn_mul);

    // magnitudes, negative values flipped
    a_mag = (is_signed && req_a[word_w-1]) ? (~req_a + word_t'(1)) : req_a;
    b_mag = (is_signed && req_b[word_w-1]) ? (~req_b + word_t'(1)) : req_b;

    op_next.fn    = req_fn;
    op_next.a_mag = a_mag;
    op_next.b_mag = b_mag;
    // product and quotient negative when the signs differ
    op_next.res_sign = is_signed && (req_a[word_w-1] ^ req_b[word_w-1]);
    // remainder follows the dividend
    op_next.rem_sign    = is_signed && req_a[word_w-1];
    op_next.dividend    = req_a;
    op_next.div_by_zero = is_div && (req_b == '0);
    op_next.is_div      = is_div;
  end

  // decoded operation stays put until the next accepted request
  always_ff @(posedge clk) begin
    if (accept) begin
      dec_op <= op_next;
    end
  end

  // start strobe for the execute stage, high the cycle after acceptance
  always_ff @(posedge clk) begin
    if (reset) begin
      dec_go <= 1'b0;
    end else begin
      dec_go <= accept;
    end
  end

  // covers the handoff cycle until an execute block reports busy
  assign busy = dec_go;

endmodule

`default_nettype wire

/* source/imuldiv_div_iter.sv */
//----------------------------------------------------------------------
// restoring divider on 32-bit magnitudes, one quotient bit per cycle
// zero divisor yields all-ones quotient, result block overrides it
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module imuldiv_div_iter (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      go,
  input  wire imuldiv_pkg::muldiv_op_t op,
  output imuldiv_pkg::exec_res_t   res,
  output logic                     done,
  output logic                     busy
);

  import imuldiv_pkg::*;

  exec_state_e state;
  step_t       count;
  logic        start;

  // remainder in the upper half, dividend bits shifting out of the lower
  dword_t rem_reg;
  word_t  dvs_reg;

  // upper half after the shift needs one extra bit
  logic [word_w:0] upper;
  logic [word_w:0] diff;

  assign start = go && op.is_div;

  // trial subtraction against the shifted partial remainder
  assign upper = rem_reg[2*word_w-1:word_w-1];
  assign diff  = upper - {1'b0, dvs_reg};

  //----------------------------------------------------------------------
  // control
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (count == last_step) begin
            state <= st_done;
          end else begin
            count <= count + step_t'(1);
          end
        end
        st_done: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  //----------------------------------------------------------------------
  // datapath
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if ((state == st_idle) && start) begin
      rem_reg <= {word_t'(0), op.a_mag};
      dvs_reg <= op.b_mag;
    end else if (state == st_calc) begin
      if (!diff[word_w]) begin
        // divisor fits, keep the difference and shift in a one
        rem_reg <= {diff[word_w-1:0], rem_reg[word_w-2:0], 1'b1};
      end else begin
        // restore, plain shift with a zero quotient bit
        rem_reg <= {rem_reg[2*word_w-2:0], 1'b0};
      end
    end
  end

  // quotient low, remainder high
  assign res.value = rem_reg;
  assign done      = (state == st_done);
  assign busy      = (state != st_idle);

endmodule

`default_nettype wire

/* source/imuldiv_mul_iter.sv */
//----------------------------------------------------------------------
// shift-and-add multiplier on 32-bit magnitudes, 32 steps per product
// starts only on go with a non-divide operation, sign fixed downstream
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module imuldiv_mul_iter (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      go,
  input  wire imuldiv_pkg::muldiv_op_t op,
  output imuldiv_pkg::exec_res_t   res,
  output logic                     done,
  output logic                     busy
);

  import imuldiv_pkg::*;

  exec_state_e state;
  step_t       count;
  logic        start;

  // shifted multiplicand, shifted multiplier, running sum
  dword_t a_reg;
  word_t  b_reg;
  dword_t acc;

  // only multiply requests belong here
  assign start = go && !op.is_div;

  //----------------------------------------------------------------------
  // control
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // one multiplier bit per cycle
          if (count == last_step) begin
            state <= st_done;
          end else begin
            count <= count + step_t'(1);
          end
        end
        st_done: begin
          // done lasts exactly one cycle
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  //----------------------------------------------------------------------
  // datapath
  //----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if ((state == st_idle) && start) begin
      // load magnitudes, clear the sum
      a_reg <= {word_t'(0), op.a_mag};
      b_reg <= op.b_mag;
      acc   <= '0;
    end else if (state == st_calc) begin
      // add the shifted a when the current multiplier bit is set
      if (b_reg[0]) begin
        acc <= acc + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  assign res.value = acc;
  assign done      = (state == st_done);
  assign busy      = (state != st_idle);

endmodule

`default_nettype wire

/* source/imuldiv_pkg.sv */
//----------------------------------------------------------------------
// shared types for the iterative mul/div unit
// operand width is fixed at 32 bits, the step counter assumes 32 steps
//----------------------------------------------------------------------
`default_nettype none

package imuldiv_pkg;

  //----------------------------------------------------------------------
  // widths
  //----------------------------------------------------------------------

  localparam int unsigned word_w = 32;

  // operand or one half of a result
  typedef logic [word_w-1:0] word_t;

  // full result, product accumulator, divider partial remainder
  typedef logic [2*word_w-1:0] dword_t;

  // iteration counter, one count per result bit
  typedef logic [4:0] step_t;

  // last count of an execute run
  localparam step_t last_step = 5'd31;

  //----------------------------------------------------------------------
  // function codes and control states
  //----------------------------------------------------------------------

  typedef enum logic [2:0] {
    fn_mul  = 3'd0,
    fn_div  = 3'd1,
    fn_divu = 3'd2,
    fn_rem  = 3'd3,
    fn_remu = 3'd4
  } muldiv_fn_e;

  // control states shared by both execute blocks
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } exec_state_e;

  //----------------------------------------------------------------------
  // structs
  //----------------------------------------------------------------------

  // decoded operation, held in the decode register for the whole run
  typedef struct packed {
    muldiv_fn_e fn;
    word_t      a_mag;
    word_t      b_mag;
    logic       res_sign;
    logic       rem_sign;
    word_t      dividend;
    logic       div_by_zero;
    logic       is_div;
  } muldiv_op_t;

  // magnitude result: product, or remainder high and quotient low
  typedef struct packed {
    dword_t value;
  } exec_res_t;

endpackage

`default_nettype wire

/* source/imuldiv_result.sv */
//----------------------------------------------------------------------
// sign fix-up and response register
// op must stay stable from the done pulse through the capture edge
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module imuldiv_result (
  input  wire                      clk,
  input  wire                      reset,
  input  wire imuldiv_pkg::muldiv_op_t op,
  input  wire imuldiv_pkg::exec_res_t mul_res,
  input  wire imuldiv_pkg::exec_res_t div_res,
  input  wire                      mul_done,
  input  wire                      div_done,
  input  wire                      resp_rdy,
  output imuldiv_pkg::dword_t      resp_result,
  output logic                     resp_val,
  output logic                     busy
);

  import imuldiv_pkg::*;

  exec_res_t sel;
  word_t     quo;
  word_t     rem_mag;
  dword_t    result_next;
  logic      capture;

  assign capture = mul_done || div_done;

  always_comb begin
    sel     = op.is_div ? div_res : mul_res;
    quo     = sel.value[word_w-1:0];
    rem_mag = sel.value[2*word_w-1:word_w];

    // zero divisor rule beats the magnitude result
    if (op.div_by_zero) begin
      quo     = '1;
      rem_mag = op.dividend;
    end else begin
      if (op.res_sign) quo = ~quo + word_t'(1);
      if (op.rem_sign) rem_mag = ~rem_mag + word_t'(1);
    end

    case (op.fn)
      fn_mul:          result_next = op.res_sign ? (~sel.value + dword_t'(1)) : sel.value;
      fn_div, fn_divu: result_next = {word_t'(0), quo};
      default:         result_next = {word_t'(0), rem_mag};
    endcase
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      resp_result <= result_next;
    end
  end

  // valid holds until the response transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (capture) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  assign busy = resp_val;

endmodule

`default_nettype wire

/* source/imuldiv_unit.sv */
//----------------------------------------------------------------------
// iterative mul/div unit, one operation in flight
// fixed latency of 34 edges from request transfer to resp_val
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module imuldiv_unit (
  input  wire                      clk,
  input  wire                      reset,
  input  wire imuldiv_pkg::muldiv_fn_e req_fn,
  input  wire imuldiv_pkg::word_t  req_a,
  input  wire imuldiv_pkg::word_t  req_b,
  input  wire                      req_val,
  output logic                     req_rdy,
  output imuldiv_pkg::dword_t      resp_result,
  output logic                     resp_val,
  input  wire                      resp_rdy
);

  import imuldiv_pkg::*;

  muldiv_op_t dec_op;
  logic       dec_go;
  exec_res_t  mul_res;
  exec_res_t  div_res;
  logic       mul_done;
  logic       div_done;

  // busy levels, their union spans acceptance to response transfer
  logic dec_busy;
  logic mul_busy;
  logic div_busy;
  logic res_busy;

  assign req_rdy = ~(dec_busy | mul_busy | div_busy | res_busy);

  imuldiv_decode dec0 (
    .clk(clk), .reset(reset),
    .req_fn(req_fn), .req_a(req_a), .req_b(req_b),
    .req_val(req_val), .req_take(req_rdy),
    .dec_op(dec_op), .dec_go(dec_go), .busy(dec_busy)
  );

  imuldiv_mul_iter mul0 (
    .clk(clk), .reset(reset), .go(dec_go), .op(dec_op),
    .res(mul_res), .done(mul_done), .busy(mul_busy)
  );

  imuldiv_div_iter div0 (
    .clk(clk), .reset(reset), .go(dec_go), .op(dec_op),
    .res(div_res), .done(div_done), .busy(div_busy)
  );

  imuldiv_result res0 (
    .clk(clk), .reset(reset), .op(dec_op),
    .mul_res(mul_res), .div_res(div_res),
    .mul_done(mul_done), .div_done(div_done), .resp_rdy(resp_rdy),
    .resp_result(resp_result), .resp_val(resp_val), .busy(res_busy)
  );

endmodule

`default_nettype wire
